// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fetch_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "\*\* PASS \*\*" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// warps and threads per warp.
`define FETCH_NUM_WARPS   4
`define FETCH_NUM_THREADS 4

// outstanding fetches held in the tag queue.
`define FETCH_ICREQ_SIZE  4

// direct-mapped icache geometry, in 32-bit words.
`define FETCH_LINE_WORDS  4
`define FETCH_NUM_LINES   8

// cycles from an accepted miss to its response.
`define FETCH_MISS_DELAY  5

`endif

// ==== hdl/fetch_pkg.sv ====
`include "fetch_params.svh"

package fetch_pkg;

    typedef logic [$clog2(`FETCH_NUM_WARPS)-1:0]  warp_t;  // warp number.
    typedef logic [`FETCH_NUM_THREADS-1:0]        tmask_t; // one bit per thread.
    typedef logic [31:0]                          pc_t;    // byte address.
    typedef logic [31:0]                          instr_t;
    typedef logic [$clog2(`FETCH_ICREQ_SIZE)-1:0] tag_t;   // tag queue slot.

    // metadata parked in the tag queue while the read is in flight
    typedef struct packed {
        pc_t    pc;
        warp_t  warp;
        tmask_t tmask;
    } fetch_meta_t;

endpackage

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fetch_valid,
    input  fetch_pkg::warp_t     fetch_warp,
    input  fetch_pkg::pc_t       fetch_pc,
    input  fetch_pkg::tmask_t    fetch_tmask,
    input  logic                 freeze,
    output logic                 stall,
    output logic                 out_valid,
    output fetch_pkg::warp_t     out_warp,
    output fetch_pkg::pc_t       out_pc,
    output fetch_pkg::tmask_t    out_tmask,
    output fetch_pkg::instr_t    out_instr,
    output logic                 out_response
);

    logic                              req_valid, req_ready;
    logic [$bits(fetch_pkg::pc_t)-3:0] req_addr;   // word address.
    fetch_pkg::tag_t                   req_tag;
    logic                              rsp_valid, rsp_ready;
    fetch_pkg::tag_t                   rsp_tag;
    fetch_pkg::instr_t                 rsp_data;

    icache_stage stage0 (
        .clk (clk), .reset (reset),
        .fetch_valid (fetch_valid), .fetch_warp (fetch_warp),
        .fetch_pc (fetch_pc), .fetch_tmask (fetch_tmask),
        .freeze (freeze), .stall (stall),
        .req_valid (req_valid), .req_addr (req_addr), .req_tag (req_tag),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid), .rsp_tag (rsp_tag), .rsp_data (rsp_data),
        .rsp_ready (rsp_ready),
        .out_valid (out_valid), .out_warp (out_warp), .out_pc (out_pc),
        .out_tmask (out_tmask), .out_instr (out_instr), .out_response (out_response)
    );

    inst_mem imem0 (
        .clk (clk), .reset (reset),
        .req_valid (req_valid), .req_addr (req_addr), .req_tag (req_tag),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid), .rsp_tag (rsp_tag), .rsp_data (rsp_data),
        .rsp_ready (rsp_ready)
    );

endmodule

// ==== hdl/icache_stage.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module icache_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              fetch_valid,
    input  fetch_pkg::warp_t                  fetch_warp,
    input  fetch_pkg::pc_t                    fetch_pc,
    input  fetch_pkg::tmask_t                 fetch_tmask,
    input  logic                              freeze,
    output logic                              stall,
    output logic                              req_valid,
    output logic [$bits(fetch_pkg::pc_t)-3:0] req_addr,
    output fetch_pkg::tag_t                   req_tag,
    input  logic                              req_ready,
    input  logic                              rsp_valid,
    input  fetch_pkg::tag_t                   rsp_tag,
    input  fetch_pkg::instr_t                 rsp_data,
    output logic                              rsp_ready,
    output logic                              out_valid,
    output fetch_pkg::warp_t                  out_warp,
    output fetch_pkg::pc_t                    out_pc,
    output fetch_pkg::tmask_t                 out_tmask,
    output fetch_pkg::instr_t                 out_instr,
    output logic                              out_response
);

    logic                   valid_inst;
    logic                   q_push, q_pop, q_full, q_empty;
    fetch_pkg::tag_t        q_write_addr;
    fetch_pkg::fetch_meta_t q_write_data;
    fetch_pkg::fetch_meta_t rd_meta;
    fetch_pkg::tag_t        rd_slot;

    assign valid_inst = fetch_valid && (|fetch_tmask);  // empty mask is dropped.

    assign req_valid = valid_inst && !q_full;
    assign req_addr  = fetch_pc[$bits(fetch_pkg::pc_t)-1:2];
    assign req_tag   = q_write_addr;
    assign stall     = q_full || !req_ready;

    assign q_write_data.pc    = fetch_pc;
    assign q_write_data.warp  = fetch_warp;
    assign q_write_data.tmask = fetch_tmask;

    assign q_push    = req_valid && req_ready;
    assign rsp_ready = !freeze;
    assign q_pop     = rsp_valid && rsp_ready;

    indexable_queue #(
        .payload_t (fetch_pkg::fetch_meta_t),
        .SIZE      (`FETCH_ICREQ_SIZE)
    ) tag_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (q_push),
        .write_data (q_write_data),
        .write_addr (q_write_addr),
        .full       (q_full),
        .pop        (q_pop),
        .read_addr  (rsp_tag),
        .read_data  ({rd_slot, rd_meta}),
        .empty      (q_empty)
    );

    // join response and metadata by tag
    assign out_valid    = q_pop;
    assign out_response = q_pop;
    assign out_pc       = rd_meta.pc;
    assign out_warp     = rd_meta.warp;
    assign out_tmask    = q_pop ? rd_meta.tmask : '0;
    assign out_instr    = rsp_data;

    a_tag_matches_slot: assert property (
        @(posedge clk) disable iff (reset) q_pop |-> (rd_slot == rsp_tag)
    );

    // a response needs something in flight
    a_rsp_has_entry: assert property (
        @(posedge clk) disable iff (reset) rsp_valid |-> !q_empty
    );

endmodule

// ==== hdl/indexable_queue.sv ====
`timescale 1ns/1ps

module indexable_queue #(
    parameter type payload_t = logic,
    parameter int  SIZE      = 4,
    localparam int IDX_W     = (SIZE > 1) ? $clog2(SIZE) : 1
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             push,
    input  payload_t                         write_data,
    output logic [IDX_W-1:0]                 write_addr,
    output logic                             full,
    input  logic                             pop,
    input  logic [IDX_W-1:0]                 read_addr,
    output logic [IDX_W+$bits(payload_t)-1:0] read_data,
    output logic                             empty
);

    logic [SIZE-1:0]  valid_q;
    payload_t         data_q [SIZE];
    logic [IDX_W-1:0] slot_q [SIZE];       // index recorded at push.

    // lowest free slot wins
    always_comb begin
        write_addr = '0;
        for (int i = SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                write_addr = IDX_W'(i);
            end
        end
    end

    assign full  = &valid_q;
    assign empty = ~|valid_q;

    assign read_data = {slot_q[read_addr], data_q[read_addr]}; // check field on top.

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            if (push) begin
                valid_q[write_addr] <= 1'b1;
            end
            if (pop) begin
                valid_q[read_addr] <= 1'b0;  // never the slot being pushed.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_q[write_addr] <= write_data;
            slot_q[write_addr] <= write_addr;
        end
    end

    a_push_not_full: assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    );

    a_pop_valid_slot: assert property (
        @(posedge clk) disable iff (reset) pop |-> valid_q[read_addr]
    );

endmodule

// ==== hdl/inst_mem.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module inst_mem (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    input  logic [$bits(fetch_pkg::pc_t)-3:0]  req_addr,
    input  fetch_pkg::tag_t                    req_tag,
    output logic                               req_ready,
    output logic                               rsp_valid,
    output fetch_pkg::tag_t                    rsp_tag,
    output fetch_pkg::instr_t                  rsp_data,
    input  logic                               rsp_ready
);

    localparam int ADDR_W = $bits(fetch_pkg::pc_t) - 2;
    localparam int OFF_W  = $clog2(`FETCH_LINE_WORDS);
    localparam int IDX_W  = $clog2(`FETCH_NUM_LINES);
    localparam int TAG_W  = ADDR_W - OFF_W - IDX_W;
    localparam int CNT_W  = $clog2(`FETCH_MISS_DELAY + 1);

    // rom rule: halves swapped, then xor
    function automatic fetch_pkg::instr_t rom_word(input logic [ADDR_W-1:0] a);
        logic [31:0] w;
        w = 32'(a);
        return {w[15:0], w[31:16]} ^ 32'h5a5a_0000;
    endfunction

    logic [`FETCH_NUM_LINES-1:0] line_valid;
    logic [TAG_W-1:0]            tag_arr [`FETCH_NUM_LINES];

    logic                  miss_busy;
    logic [CNT_W-1:0]      miss_cnt;
    logic [ADDR_W-1:0]     miss_addr_q;
    fetch_pkg::tag_t       miss_tag_q;

    logic [IDX_W-1:0] req_idx, miss_idx;
    logic             hit, rsp_free, miss_done, accept, hit_load, miss_start, miss_load;

    assign req_idx  = req_addr[OFF_W +: IDX_W];
    assign miss_idx = miss_addr_q[OFF_W +: IDX_W];
    assign hit      = line_valid[req_idx] && (tag_arr[req_idx] == req_addr[ADDR_W-1 -: TAG_W]);

    assign rsp_free  = !rsp_valid || rsp_ready;   // register empty after this edge.
    assign miss_done = miss_busy && (miss_cnt == CNT_W'(1));
    assign req_ready = rsp_free && !miss_done && !(!hit && miss_busy);

    assign accept     = req_valid && req_ready;
    assign hit_load   = accept && hit;
    assign miss_start = accept && !hit;
    assign miss_load  = miss_done && rsp_free;     // finished miss goes first.

    always_ff @(posedge clk) begin
        if (reset) begin
            miss_busy  <= 1'b0;
            miss_cnt   <= '0;
            line_valid <= '0;
            rsp_valid  <= 1'b0;
        end else begin
            if (miss_start) begin
                miss_busy <= 1'b1;
                miss_cnt  <= CNT_W'(`FETCH_MISS_DELAY - 1);
            end else if (miss_load) begin
                miss_busy            <= 1'b0;
                miss_cnt             <= '0;
                line_valid[miss_idx] <= 1'b1;  // refill done.
            end else if (miss_busy && miss_cnt > CNT_W'(1)) begin
                miss_cnt <= miss_cnt - 1'b1;
            end
            if (miss_load || hit_load) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_addr_q <= req_addr;
            miss_tag_q  <= req_tag;
        end
        if (miss_load) begin
            tag_arr[miss_idx] <= miss_addr_q[ADDR_W-1 -: TAG_W];
            rsp_tag           <= miss_tag_q;
            rsp_data          <= rom_word(miss_addr_q);
        end else if (hit_load) begin
            rsp_tag  <= req_tag;
            rsp_data <= rom_word(req_addr);
        end
    end

    // held response must survive until taken
    a_rsp_held: assert property (
        @(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_tag) && $stable(rsp_data))
    );

endmodule

// ==== project.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/indexable_queue.sv
hdl/inst_mem.sv
hdl/icache_stage.sv
hdl/fetch_top.sv
sim/fetch_tb.sv

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb;

    localparam int NUM_ROWS       = 16;
    localparam int NUM_RANDOM     = 4;   // last rows get random freeze lengths.
    localparam int MAX_FREEZE     = 8;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (`FETCH_MISS_DELAY + MAX_FREEZE + 4);

    typedef struct packed {
        fetch_pkg::pc_t    pc;
        fetch_pkg::warp_t  warp;
        fetch_pkg::tmask_t tmask;
    } expect_t;

    logic              clk = 1'b0;
    logic              reset;
    logic              fetch_valid;
    fetch_pkg::warp_t  fetch_warp;
    fetch_pkg::pc_t    fetch_pc;
    fetch_pkg::tmask_t fetch_tmask;
    logic              freeze;
    logic              stall;
    logic              out_valid;
    fetch_pkg::warp_t  out_warp;
    fetch_pkg::pc_t    out_pc;
    fetch_pkg::tmask_t out_tmask;
    fetch_pkg::instr_t out_instr;
    logic              out_response;

    fetch_pkg::warp_t  row_warp   [NUM_ROWS];
    fetch_pkg::pc_t    row_pc     [NUM_ROWS];
    fetch_pkg::tmask_t row_tmask  [NUM_ROWS];
    int                row_freeze [NUM_ROWS];

    expect_t sb [$];   // in acceptance order.
    int      errors = 0;
    int      checks = 0;
    int      issued = 0;
    int      matched = 0;
    int      overtakes = 0;
    int      freeze_left = 0;
    int      cycle_count = 0;
    logic    freeze_stall_seen = 1'b0;

    always #2 clk = ~clk;

    fetch_top dut0 (
        .clk (clk), .reset (reset),
        .fetch_valid (fetch_valid), .fetch_warp (fetch_warp),
        .fetch_pc (fetch_pc), .fetch_tmask (fetch_tmask),
        .freeze (freeze), .stall (stall),
        .out_valid (out_valid), .out_warp (out_warp), .out_pc (out_pc),
        .out_tmask (out_tmask), .out_instr (out_instr), .out_response (out_response)
    );

    // word address with its halves swapped, then xor
    function automatic logic [31:0] expected_instr(input logic [31:0] pc);
        logic [31:0] word_addr;
        word_addr = {2'b00, pc[31:2]};
        return {word_addr[15:0], word_addr[31:16]} ^ 32'h5a5a_0000;
    endfunction

    task automatic set_row(input int r, input logic [1:0] w, input logic [31:0] pc,
                           input logic [3:0] m, input int frz);
        row_warp[r]   = w;
        row_pc[r]     = pc;
        row_tmask[r]  = m;
        row_freeze[r] = frz;
    endtask

    task automatic load_table();
        set_row(0,  2'd0, 32'h0000_0000, 4'hf, 0);  // cold miss, line 0.
        set_row(1,  2'd1, 32'h0000_0004, 4'h3, 0);
        set_row(2,  2'd2, 32'h0000_00a0, 4'h5, 0);  // miss, line 2.
        set_row(3,  2'd3, 32'h0000_0008, 4'h8, 0);  // hit overtakes row 2.
        set_row(4,  2'd0, 32'h0000_0400, 4'h0, 0);  // dropped.
        set_row(5,  2'd1, 32'h0000_000c, 4'h1, MAX_FREEZE);
        set_row(6,  2'd2, 32'h0000_00a4, 4'h2, 0);
        set_row(7,  2'd3, 32'h0000_00a8, 4'h4, 0);
        set_row(8,  2'd0, 32'h0000_00ac, 4'h6, 0);
        set_row(9,  2'd1, 32'h0000_0010, 4'h9, 0);
        set_row(10, 2'd2, 32'h0000_0014, 4'ha, 0);
        set_row(11, 2'd3, 32'h0000_0018, 4'hc, 3);
        set_row(12, 2'd0, 32'h0000_0200, 4'he, 0);  // evicts line 0.
        set_row(13, 2'd1, 32'h0000_0204, 4'h7, 0);
        set_row(14, 2'd2, 32'h0000_0030, 4'hb, 0);
        set_row(15, 2'd3, 32'h0000_0214, 4'hd, 0);
        for (int r = NUM_ROWS - NUM_RANDOM; r < NUM_ROWS; r++) begin
            row_freeze[r] = int'($urandom % (MAX_FREEZE + 1));
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        freeze = (freeze_left > 0);
        if (freeze_left > 0) begin
            freeze_left--;
        end
    endtask

    // present one row until it is taken
    task automatic apply_row(input int r);
        next_cycle();
        fetch_valid = 1'b1;
        fetch_warp  = row_warp[r];
        fetch_pc    = row_pc[r];
        fetch_tmask = row_tmask[r];
        #1;
        while (stall) begin
            next_cycle();
            #1;
        end
        if (row_tmask[r] != '0) begin
            sb.push_back(expect_t'{pc: row_pc[r], warp: row_warp[r], tmask: row_tmask[r]});
            issued++;
        end
        if (row_freeze[r] > freeze_left) begin
            freeze_left = row_freeze[r];
        end
    endtask

    // scoreboard, keyed by pc and warp
    always @(negedge clk) begin
        int k;
        #1;
        k = -1;
        if (!reset && freeze && stall) begin
            freeze_stall_seen = 1'b1;
        end
        if (!reset && out_valid) begin
            for (int i = sb.size() - 1; i >= 0; i--) begin
                if (sb[i].pc == out_pc && sb[i].warp == out_warp) begin
                    k = i;
                end
            end
            checks++;
            assert (out_response) else begin
                errors++;
                $display("out_response is low while out_valid is high");
            end
            assert (k >= 0) else begin
                errors++;
                $display("response for pc %h warp %h matches no pending fetch", out_pc, out_warp);
            end
            if (k >= 0) begin
                assert (out_tmask == sb[k].tmask) else begin
                    errors++;
                    $display("error: out_tmask got %h expected %h", out_tmask, sb[k].tmask);
                end
                assert (out_instr == expected_instr(sb[k].pc)) else begin
                    errors++;
                    $display("error: out_instr got %h expected %h", out_instr,
                             expected_instr(sb[k].pc));
                end
                if (k > 0) begin
                    overtakes++;  // an older fetch is still pending.
                end
                sb.delete(k);
                matched++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_warp  = '0;
        fetch_pc    = '0;
        fetch_tmask = '0;
        freeze      = 1'b0;
        void'($urandom(32'h163c444e));
        load_table();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        next_cycle();
        fetch_valid = 1'b0;
        fetch_tmask = '0;
        while (sb.size() != 0) begin
            next_cycle();
        end
        repeat (`FETCH_MISS_DELAY + 4) next_cycle();  // catch stray responses.
        assert (checks == issued) else begin
            errors++;
            $display("error: checks got %h expected %h", checks, issued);
        end
        assert (overtakes > 0) else begin
            errors++;
            $display("no response ever overtook an older fetch");
        end
        assert (freeze_stall_seen) else begin
            errors++;
            $display("stall never rose while freeze was held");
        end
        $display("issued %0d, matched %0d, checks %0d, overtakes %0d, errors %0d",
                 issued, matched, checks, overtakes, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
